// File: cpu_pkg.sv
/*
  shared types for the 8-bit core
  opcode map, timing states, debug selects and bus widths
*/
package cpu_pkg;

  localparam int data_w   = 8;   // data bus and register width
  localparam int addr_w   = 16;  // address bus width
  localparam int regsel_w = 4;   // debug select width

  typedef logic [data_w-1:0] byte_t;
  typedef logic [addr_w-1:0] addr_t;

  // supported opcodes, 6502 encodings
  typedef enum byte_t {
    op_brk     = 8'h00,
    op_lda_imm = 8'hA9,
    op_lda_zp  = 8'hA5,
    op_lda_zpx = 8'hB5,
    op_ldx_imm = 8'hA2,
    op_ldx_zp  = 8'hA6,
    op_ldx_zpy = 8'hB6,
    op_ldy_imm = 8'hA0,
    op_ldy_zp  = 8'hA4,
    op_ldy_zpx = 8'hB4,
    op_nop     = 8'hEA,
    op_sta_zp  = 8'h85,
    op_sta_zpx = 8'h95,
    op_stx_zp  = 8'h86,
    op_stx_zpy = 8'h96,
    op_sty_zp  = 8'h84,
    op_sty_zpx = 8'h94
  } opcode_e;

  // timing states of the sequencer
  typedef enum logic [2:0] {
    t0  = 3'd0,
    t1  = 3'd1,
    t1x = 3'd2,  // unused by this opcode set
    t2  = 3'd3,
    t3  = 3'd4,
    t4  = 3'd5,
    t5  = 3'd6,
    t6  = 3'd7
  } tstate_e;

  // debug register selects
  typedef enum logic [regsel_w-1:0] {
    regsel_pcl = 4'd0,
    regsel_pch = 4'd1,
    regsel_ac  = 4'd2,
    regsel_x   = 4'd3,
    regsel_y   = 4'd4,
    regsel_p   = 4'd5
  } regsel_e;

  localparam byte_t dbg_default = 8'hBD;  // unused select readback

endpackage

// File: cpu_ctrl_if.sv
/*
  control strobes from the decode ROM to the datapath
  all levels, held for one processor cycle
*/
`timescale 1ns/1ps

interface cpu_ctrl_if;

  logic load_prg_byte;     // pc to address bus, pc increment
  logic lda_last;          // final cycle of lda
  logic ldx_last;          // final cycle of ldx
  logic ldy_last;          // final cycle of ldy
  logic ac_to_dor;         // a into data out reg
  logic x_to_dor;          // x into data out reg
  logic y_to_dor;          // y into data out reg
  logic zp_addr_to_ab;     // dl as zero-page address
  logic zpidx_addr_to_ab;  // adder result as zero-page address
  logic zpx_comps_to_alu;  // operand and x into adder inputs
  logic zpy_comps_to_alu;  // operand and y into adder inputs

  modport decode (
    output load_prg_byte, lda_last, ldx_last, ldy_last,
           ac_to_dor, x_to_dor, y_to_dor,
           zp_addr_to_ab, zpidx_addr_to_ab,
           zpx_comps_to_alu, zpy_comps_to_alu
  );

  modport datapath (
    input  load_prg_byte, lda_last, ldx_last, ldy_last,
           ac_to_dor, x_to_dor, y_to_dor,
           zp_addr_to_ab, zpidx_addr_to_ab,
           zpx_comps_to_alu, zpy_comps_to_alu
  );

endinterface

// File: cpu_timing.sv
/*
  timing generator
  ready latch, four-phase clock enables, T-state sequencer and instruction fetch regs
*/
`timescale 1ns/1ps

module cpu_timing
(
  input  logic             clk,
  input  logic             rst,
  input  logic             ready,        // external ready level
  input  cpu_pkg::byte_t   din,          // read data
  output logic             ph1_en,       // phase-1 register update
  output logic             ph2_en,       // phase-2 register update
  output logic             cycle_start,  // first clk of a processor cycle
  output cpu_pkg::tstate_e t_state,
  output cpu_pkg::byte_t   ir
);
  import cpu_pkg::*;

  logic       ready_q;  // ready delayed one clk
  logic       rdy;
  logic [1:0] phase;
  tstate_e    t_next;
  byte_t      pd;       // pre-decode reg
  logic       is_prefetch;
  logic       is_imm;
  logic       is_zp;
  logic       is_zpidx;

  assign rdy         = ready && ready_q;
  assign ph1_en      = rdy && (phase == 2'd0);
  assign cycle_start = rdy && (phase == 2'd1);
  assign ph2_en      = rdy && (phase == 2'd2);

  ////////////////////////////////////////
  // opcode classes

  assign is_prefetch = (ir == op_brk) || (ir == op_nop);  // fetch next opcode in t1
  assign is_imm      = ir inside {op_lda_imm, op_ldx_imm, op_ldy_imm};
  assign is_zp       = ir inside {op_lda_zp, op_ldx_zp, op_ldy_zp,
                                  op_sta_zp, op_stx_zp, op_sty_zp};
  assign is_zpidx    = ir inside {op_lda_zpx, op_ldx_zpy, op_ldy_zpx,
                                  op_sta_zpx, op_stx_zpy, op_sty_zpx};

  // next T-state, loads and stores exit early since the bus is busy in their last cycle
  always_comb
  begin
    case (t_state)
      t0:      t_next = t1;
      t1, t1x: t_next = is_prefetch ? t1 : (is_imm ? t0 : t2);
      t2:      t_next = is_zp ? t0 : t3;
      t3:      t_next = is_zpidx ? t0 : t4;
      t4:      t_next = t5;
      t5:      t_next = t6;
      t6:      t_next = t0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ready_q <= 1'b0;
      phase   <= 2'd1;
      t_state <= t1;
      ir      <= op_brk;  // first decoded cycle is a brk
    end
    else
    begin
      ready_q <= ready;
      if (rdy)
        phase <= phase + 2'd1;  // counter freezes on a stall
      if (ph1_en)
      begin
        t_state <= t_next;
        if (t_next == t1)
          ir <= pd;  // new opcode enters on t1
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (ph2_en)
      pd <= din;
  end

  // known opcodes stay inside t0..t3
  assert property (@(posedge clk) disable iff (rst)
    (is_prefetch || is_imm || is_zp || is_zpidx) |-> !(t_state inside {t1x, t4, t5, t6}))
    else $error("t_state outside supported range for opcode %h", ir);

endmodule

// File: cpu_decode.sv
/*
  decode ROM
  maps T-state and opcode to datapath strobes, r_nw and the brk pulse
*/
`timescale 1ns/1ps

module cpu_decode
(
  input  cpu_pkg::tstate_e t_state,
  input  cpu_pkg::byte_t   ir,
  input  logic             cycle_start,
  cpu_ctrl_if.decode       ctrl,
  output logic             r_nw,  // low for a store data cycle
  output logic             brk    // debug break pulse
);
  import cpu_pkg::*;

  always_comb
  begin
    // everything idle unless a state says otherwise
    ctrl.load_prg_byte    = 1'b0;
    ctrl.lda_last         = 1'b0;
    ctrl.ldx_last         = 1'b0;
    ctrl.ldy_last         = 1'b0;
    ctrl.ac_to_dor        = 1'b0;
    ctrl.x_to_dor         = 1'b0;
    ctrl.y_to_dor         = 1'b0;
    ctrl.zp_addr_to_ab    = 1'b0;
    ctrl.zpidx_addr_to_ab = 1'b0;
    ctrl.zpx_comps_to_alu = 1'b0;
    ctrl.zpy_comps_to_alu = 1'b0;
    r_nw                  = 1'b1;
    brk                   = 1'b0;

    case (t_state)
      t0:
        ctrl.load_prg_byte = 1'b1;  // opcode fetch
      t1:
      begin
        case (ir)
          op_brk:
          begin
            ctrl.load_prg_byte = 1'b1;
            brk                = cycle_start;  // once per cycle
          end
          op_nop:     ctrl.load_prg_byte = 1'b1;
          op_lda_imm: {ctrl.load_prg_byte, ctrl.lda_last} = 2'b11;
          op_ldx_imm: {ctrl.load_prg_byte, ctrl.ldx_last} = 2'b11;
          op_ldy_imm: {ctrl.load_prg_byte, ctrl.ldy_last} = 2'b11;
          op_lda_zp, op_ldx_zp, op_ldy_zp:
            ctrl.zp_addr_to_ab = 1'b1;
          op_sta_zp:  {ctrl.zp_addr_to_ab, ctrl.ac_to_dor} = 2'b11;
          op_stx_zp:  {ctrl.zp_addr_to_ab, ctrl.x_to_dor}  = 2'b11;
          op_sty_zp:  {ctrl.zp_addr_to_ab, ctrl.y_to_dor}  = 2'b11;
          op_lda_zpx, op_ldy_zpx, op_sta_zpx, op_sty_zpx:
            ctrl.zpx_comps_to_alu = 1'b1;  // base + x
          op_ldx_zpy, op_stx_zpy:
            ctrl.zpy_comps_to_alu = 1'b1;  // base + y
          default: ;
        endcase
      end
      t2:
      begin
        case (ir)
          op_lda_zp: {ctrl.load_prg_byte, ctrl.lda_last} = 2'b11;
          op_ldx_zp: {ctrl.load_prg_byte, ctrl.ldx_last} = 2'b11;
          op_ldy_zp: {ctrl.load_prg_byte, ctrl.ldy_last} = 2'b11;
          op_sta_zp, op_stx_zp, op_sty_zp:
          begin
            ctrl.load_prg_byte = 1'b1;
            r_nw               = 1'b0;  // zp write cycle
          end
          op_lda_zpx, op_ldx_zpy, op_ldy_zpx:
            ctrl.zpidx_addr_to_ab = 1'b1;
          op_sta_zpx: {ctrl.zpidx_addr_to_ab, ctrl.ac_to_dor} = 2'b11;
          op_stx_zpy: {ctrl.zpidx_addr_to_ab, ctrl.x_to_dor}  = 2'b11;
          op_sty_zpx: {ctrl.zpidx_addr_to_ab, ctrl.y_to_dor}  = 2'b11;
          default: ;
        endcase
      end
      t3:
      begin
        case (ir)
          op_lda_zpx: {ctrl.load_prg_byte, ctrl.lda_last} = 2'b11;
          op_ldx_zpy: {ctrl.load_prg_byte, ctrl.ldx_last} = 2'b11;
          op_ldy_zpx: {ctrl.load_prg_byte, ctrl.ldy_last} = 2'b11;
          op_sta_zpx, op_stx_zpy, op_sty_zpx:
          begin
            ctrl.load_prg_byte = 1'b1;
            r_nw               = 1'b0;  // indexed write cycle
          end
          default: ;
        endcase
      end
      default: ;
    endcase
  end

  // one address source per cycle, sampled as each cycle_start pulse ends
  assert property (@(negedge cycle_start)
    $onehot0({ctrl.load_prg_byte, ctrl.zp_addr_to_ab, ctrl.zpidx_addr_to_ab}))
    else $error("more than one address source in state %s", t_state.name());

endmodule

// File: cpu_datapath.sv
/*
  datapath with ADL/ADH/DB/SB buses, A/X/Y, N/Z, zero-page adder and PC
  drives the address and data buses and the debug read port
*/
`timescale 1ns/1ps

module cpu_datapath
#(
  parameter cpu_pkg::byte_t reset_pch = 8'h80  // high byte of reset pc
)
(
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          ph1_en,
  input  logic                          ph2_en,
  input  cpu_pkg::byte_t                din,
  input  logic [cpu_pkg::regsel_w-1:0]  dbgreg_sel,
  cpu_ctrl_if.datapath                  ctrl,
  output cpu_pkg::byte_t                dout,
  output cpu_pkg::addr_t                a,
  output cpu_pkg::byte_t                dbgreg_out
);
  import cpu_pkg::*;

  byte_t ac_q;
  byte_t x_q;
  byte_t y_q;
  logic  n_q;
  logic  z_q;
  byte_t p;      // status, n in bit 7 and z in bit 1
  addr_t pc_q;
  byte_t abl_q;  // address bus low
  byte_t abh_q;  // address bus high
  byte_t dl_q;   // input data latch
  byte_t dor_q;  // data output reg
  byte_t ai_q;   // adder input a
  byte_t bi_q;   // adder input b
  byte_t add_q;  // adder hold reg

  // bus drive and load enables
  logic ld_last;
  logic alu_in;
  logic ab_load;
  logic pcl_adl;
  logic dl_adl;
  logic add_adl;
  logic pch_adh;
  logic ac_db;
  logic dl_db;
  logic x_sb;
  logic y_sb;
  logic sb_db;   // sb/db pass path

  byte_t adl;
  byte_t adh;
  byte_t db_in;
  byte_t db_out;
  byte_t sb_in;
  byte_t sb_out;

  ////////////////////////////////////////
  // strobe to enable mapping

  assign ld_last = ctrl.lda_last | ctrl.ldx_last | ctrl.ldy_last;
  assign alu_in  = ctrl.zpx_comps_to_alu | ctrl.zpy_comps_to_alu;
  assign ab_load = ctrl.load_prg_byte | ctrl.zp_addr_to_ab | ctrl.zpidx_addr_to_ab;
  assign pcl_adl = ctrl.load_prg_byte;
  assign dl_adl  = ctrl.zp_addr_to_ab;
  assign add_adl = ctrl.zpidx_addr_to_ab;
  assign pch_adh = ctrl.load_prg_byte;  // otherwise adh floats to page zero
  assign ac_db   = ctrl.ac_to_dor;
  assign dl_db   = ld_last | alu_in;
  assign x_sb    = ctrl.zpx_comps_to_alu | ctrl.x_to_dor;
  assign y_sb    = ctrl.zpy_comps_to_alu | ctrl.y_to_dor;
  assign sb_db   = ld_last | ctrl.x_to_dor | ctrl.y_to_dor;

  ////////////////////////////////////////
  // internal buses, undriven bus reads zero

  assign adl    = pcl_adl ? pc_q[7:0] : (dl_adl ? dl_q : (add_adl ? add_q : '0));
  assign adh    = pch_adh ? pc_q[15:8] : '0;
  assign db_in  = dl_db ? dl_q : (ac_db ? ac_q : '0);
  assign sb_in  = x_sb ? x_q : (y_sb ? y_q : '0);
  assign db_out = sb_db ? (db_in | sb_in) : db_in;  // pass path merges both sides
  assign sb_out = sb_db ? (sb_in | db_in) : sb_in;

  // phase-1 control and user state
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ac_q  <= '0;
      x_q   <= '0;
      y_q   <= '0;
      n_q   <= 1'b0;
      z_q   <= 1'b0;
      abl_q <= '0;
      abh_q <= reset_pch;
    end
    else if (ph1_en)
    begin
      if (ctrl.lda_last)
        ac_q <= sb_out;
      if (ctrl.ldx_last)
        x_q <= sb_out;
      if (ctrl.ldy_last)
        y_q <= sb_out;
      if (ld_last)
      begin
        n_q <= db_out[7];
        z_q <= ~|db_out;
      end
      if (ab_load)
      begin
        abl_q <= adl;
        abh_q <= adh;
      end
    end
  end

  // phase-1 payload
  always_ff @(posedge clk)
  begin
    if (ph1_en)
    begin
      dor_q <= db_out;
      if (alu_in)
      begin
        ai_q <= sb_out;  // index reg
        bi_q <= db_out;  // zp base
      end
    end
  end

  // phase-2 pc
  always_ff @(posedge clk)
  begin
    if (rst)
      pc_q <= {reset_pch, 8'h00};
    else if (ph2_en && ctrl.load_prg_byte)
      pc_q <= pc_q + addr_t'(1);
  end

  // phase-2 payload, 8-bit add wraps inside page zero
  always_ff @(posedge clk)
  begin
    if (ph2_en)
    begin
      dl_q <= din;
      if (ctrl.zpidx_addr_to_ab)
        add_q <= ai_q + bi_q;
    end
  end

  assign p    = {n_q, 5'b00000, z_q, 1'b0};
  assign dout = dor_q;
  assign a    = {abh_q, abl_q};

  always_comb
  begin
    case (dbgreg_sel)
      regsel_pcl: dbgreg_out = pc_q[7:0];
      regsel_pch: dbgreg_out = pc_q[15:8];
      regsel_ac:  dbgreg_out = ac_q;
      regsel_x:   dbgreg_out = x_q;
      regsel_y:   dbgreg_out = y_q;
      regsel_p:   dbgreg_out = p;
      default:    dbgreg_out = dbg_default;
    endcase
  end

  // pc only moves on a phase-2 enable
  assert property (@(posedge clk) disable iff (rst) !ph2_en |=> $stable(pc_q))
    else $error("pc changed outside phase 2");

endmodule

// File: cpu_top.sv
/*
  8-bit core top level
  timing, decode ROM and datapath joined by the control strobe bundle
*/
`timescale 1ns/1ps

module cpu_top
#(
  parameter cpu_pkg::byte_t reset_pch = 8'h80  // reset pc is {reset_pch, 00}
)
(
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         ready,       // low stalls the core
  input  cpu_pkg::byte_t               din,
  input  logic [cpu_pkg::regsel_w-1:0] dbgreg_sel,
  output cpu_pkg::byte_t               dout,
  output cpu_pkg::addr_t               a,
  output logic                         r_nw,
  output logic                         brk,
  output cpu_pkg::byte_t               dbgreg_out
);
  import cpu_pkg::*;

  logic    ph1_en;
  logic    ph2_en;
  logic    cycle_start;
  tstate_e t_state;
  byte_t   ir;

  cpu_ctrl_if u_ctrl_if ();  // decode to datapath strobes

  cpu_timing u_timing (
    .clk         (clk),
    .rst         (rst),
    .ready       (ready),
    .din         (din),
    .ph1_en      (ph1_en),
    .ph2_en      (ph2_en),
    .cycle_start (cycle_start),
    .t_state     (t_state),
    .ir          (ir)
  );

  cpu_decode u_decode (
    .t_state     (t_state),
    .ir          (ir),
    .cycle_start (cycle_start),
    .ctrl        (u_ctrl_if.decode),
    .r_nw        (r_nw),
    .brk         (brk)
  );

  cpu_datapath #(
    .reset_pch (reset_pch)
  ) u_datapath (
    .clk        (clk),
    .rst        (rst),
    .ph1_en     (ph1_en),
    .ph2_en     (ph2_en),
    .din        (din),
    .dbgreg_sel (dbgreg_sel),
    .ctrl       (u_ctrl_if.datapath),
    .dout       (dout),
    .a          (a),
    .dbgreg_out (dbgreg_out)
  );

endmodule

// File: tb_cpu.sv
/*
  testbench for the 8-bit core
  memory model, random program from a fixed seed, reference model and checks
*/
`timescale 1ns/1ps

module tb_cpu;
  import cpu_pkg::*;

  localparam int n_instr   = 19;  // program length, final brk included
  localparam int clk_limit = ((n_instr + 1) * 40 + 16) * 4;  // 40 cycles per instr, 4 clk each
  localparam int t_reset   = 0;   // test slots
  localparam int t_writes  = 1;
  localparam int t_stall   = 2;
  localparam int t_brk     = 3;
  localparam int t_debug   = 4;

  logic       clk;
  logic       rst;
  logic       ready;
  byte_t      din;
  logic [3:0] dbgreg_sel;
  byte_t      dout;
  addr_t      a;
  logic       r_nw;
  logic       brk;
  byte_t      dbgreg_out;

  byte_t mem [0:65535];
  byte_t zp_model [0:255];          // model copy of page zero
  byte_t prog_op [0:n_instr-1];
  byte_t prog_arg [0:n_instr-1];
  addr_t exp_wr_addr [$];           // writes in program order
  byte_t exp_wr_data [$];

  byte_t m_ac;
  byte_t m_x;
  byte_t m_y;
  logic  m_n;
  logic  m_z;
  addr_t brk_addr;                  // where the final brk sits
  int    errs [0:4];
  int    brk_count;
  int    stall_count;
  int    cycle_count;
  int    seed_init;
  addr_t a_prev;
  byte_t dout_prev;
  logic  r_nw_prev;

  cpu_top #(
    .reset_pch (8'h80)
  ) u_dut (
    .clk        (clk),
    .rst        (rst),
    .ready      (ready),
    .din        (din),
    .dbgreg_sel (dbgreg_sel),
    .dout       (dout),
    .a          (a),
    .r_nw       (r_nw),
    .brk        (brk),
    .dbgreg_out (dbgreg_out)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;  // 100 ns period

  ////////////////////////////////////////
  // 64 KB memory, async read

  assign din = mem[a];

  always @(posedge clk)
  begin
    if (!r_nw)
      mem[a] <= dout;
  end

  function automatic byte_t fill_byte(input addr_t addr);
    return addr[7:0] ^ {addr[3:0], addr[7:4]} ^ addr[15:8] ^ 8'h3C;
  endfunction

  task automatic expect_equal(input int test, input string name,
                              input logic [15:0] got, input logic [15:0] exp);
    assert (got === exp)
    else
    begin
      $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
      errs[test]++;
    end
  endtask

  task automatic report_problem(input int test, input string msg);
    $display("ERROR t=%0t %s", $time, msg);
    errs[test]++;
  endtask

  task automatic report_test(input int test, input string name);
    if (errs[test] == 0)
      $display("test %s ok", name);
    else
      $display("test %s FAILED with %0d errors", name, errs[test]);
  endtask

  // fixed opcode order, random operands
  task automatic build_program();
    int i;
    prog_op = '{op_lda_imm, op_ldx_imm, op_ldy_imm, op_sta_zp, op_stx_zp, op_sty_zp,
                op_lda_zp, op_ldx_zp, op_ldy_zp, op_ldx_imm, op_ldy_imm,
                op_sta_zpx, op_stx_zpy, op_sty_zpx, op_lda_zpx, op_ldx_zpy, op_ldy_zpx,
                op_nop, op_brk};
    for (i = 0; i < n_instr; i++)
      prog_arg[i] = byte_t'($urandom);
    prog_arg[6] = prog_arg[4];  // read back stx location
    prog_arg[7] = prog_arg[5];  // read back sty location
    for (i = 9; i <= 13; i++)
      prog_arg[i] = prog_arg[i] | 8'h80;  // large index and base, sum wraps in page zero
    prog_arg[14] = prog_arg[11];
    prog_arg[15] = prog_arg[12];
  endtask

  task automatic load_program();
    int    i;
    addr_t pc;
    pc = 16'h8000;
    for (i = 0; i < n_instr; i++)
    begin
      mem[pc] = prog_op[i];
      pc++;
      if (!(prog_op[i] inside {op_brk, op_nop}))
      begin
        mem[pc] = prog_arg[i];  // one operand byte
        pc++;
      end
    end
  endtask

  // reference model, one instruction at a time
  task automatic predict_results();
    int    i;
    addr_t pc;
    byte_t ea;
    byte_t val;
    pc   = 16'h8000;
    m_ac = '0;
    m_x  = '0;
    m_y  = '0;
    m_n  = 1'b0;
    m_z  = 1'b0;
    for (i = 0; i < n_instr; i++)
    begin
      ea = prog_arg[i];
      if (prog_op[i] inside {op_lda_zpx, op_ldy_zpx, op_sta_zpx, op_sty_zpx})
        ea = prog_arg[i] + m_x;  // 8-bit wrap
      else if (prog_op[i] inside {op_ldx_zpy, op_stx_zpy})
        ea = prog_arg[i] + m_y;
      if (prog_op[i] inside {op_sta_zp, op_sta_zpx, op_stx_zp, op_stx_zpy,
                             op_sty_zp, op_sty_zpx})
      begin
        val = (prog_op[i] inside {op_sta_zp, op_sta_zpx}) ? m_ac :
              (prog_op[i] inside {op_stx_zp, op_stx_zpy}) ? m_x : m_y;
        zp_model[ea] = val;
        exp_wr_addr.push_back({8'h00, ea});
        exp_wr_data.push_back(val);
      end
      else if (!(prog_op[i] inside {op_brk, op_nop}))
      begin
        val = (prog_op[i] inside {op_lda_imm, op_ldx_imm, op_ldy_imm}) ? prog_arg[i]
                                                                        : zp_model[ea];
        if (prog_op[i] inside {op_lda_imm, op_lda_zp, op_lda_zpx})
          m_ac = val;
        else if (prog_op[i] inside {op_ldx_imm, op_ldx_zp, op_ldx_zpy})
          m_x = val;
        else
          m_y = val;
        m_n = val[7];
        m_z = (val == 8'h00);
      end
      if (prog_op[i] == op_brk)
        brk_addr = pc;
      pc = pc + ((prog_op[i] inside {op_brk, op_nop}) ? 16'd1 : 16'd2);
    end
  endtask

  // per negedge, check then drive ready
  task automatic watch_cycle();
    if (!ready)
    begin
      stall_count++;
      expect_equal(t_stall, "a", a, a_prev);
      expect_equal(t_stall, "dout", dout, dout_prev);
      expect_equal(t_stall, "r_nw", r_nw, r_nw_prev);
    end
    if (!r_nw && r_nw_prev)  // new write cycle
    begin
      if (exp_wr_addr.size() == 0)
        report_problem(t_writes, "write cycle seen with no write left in the program");
      else
      begin
        expect_equal(t_writes, "a", a, exp_wr_addr.pop_front());
        expect_equal(t_writes, "dout", dout, exp_wr_data.pop_front());
      end
    end
    if (brk)
    begin
      brk_count++;
      if (brk_count == 1)
        expect_equal(t_brk, "a", a, 16'h8000);
      else
        expect_equal(t_brk, "a", a, brk_addr + 16'd1);  // a stray brk lands elsewhere
      if (brk_count == 2 && exp_wr_addr.size() != 0)
        report_problem(t_writes, "program ended before all expected writes were seen");
    end
    a_prev    = a;
    dout_prev = dout;
    r_nw_prev = r_nw;
    if (brk_count >= 2)
      ready = 1'b0;  // freeze the core for debug reads
    else if (brk)
      ready = 1'b1;  // keep each brk pulse one clk wide
    else
      ready = (($urandom % 6) != 0);
  endtask

  task automatic read_debug(input logic [3:0] sel, input string name, input byte_t exp);
    dbgreg_sel = sel;
    @(negedge clk);
    expect_equal(t_debug, name, dbgreg_out, exp);
  endtask

  ////////////////////////////////////////
  // main sequence

  initial
  begin
    int    k;
    int    total;
    int    failed;
    addr_t pc_end;
    seed_init   = $urandom(8);  // seed once
    rst         = 1'b1;
    ready       = 1'b1;
    dbgreg_sel  = regsel_pcl;
    errs        = '{default: 0};
    brk_count   = 0;
    stall_count = 0;
    r_nw_prev   = 1'b1;
    for (k = 0; k < 65536; k++)
      mem[k] = fill_byte(addr_t'(k));
    for (k = 0; k < 256; k++)
      zp_model[k] = fill_byte(addr_t'(k));
    build_program();
    load_program();
    predict_results();

    repeat (3)
    begin
      @(negedge clk);
      expect_equal(t_reset, "r_nw", r_nw, 1'b1);
      expect_equal(t_reset, "brk", brk, 1'b0);
      expect_equal(t_reset, "a", a, 16'h8000);
    end
    rst = 1'b0;
    @(negedge clk);
    expect_equal(t_reset, "r_nw", r_nw, 1'b1);
    expect_equal(t_reset, "a", a, 16'h8000);
    report_test(t_reset, "reset_state");

    while (brk_count < 2)
    begin
      watch_cycle();
      @(negedge clk);
    end
    report_test(t_writes, "program_writes");
    if (stall_count == 0)
      report_problem(t_stall, "no stalled clock was ever driven");
    report_test(t_stall, "stall_hold");
    report_test(t_brk, "brk_pulses");

    pc_end = brk_addr + 16'd1;  // brk stops before its prefetch
    read_debug(regsel_ac, "dbg_ac", m_ac);
    read_debug(regsel_x, "dbg_x", m_x);
    read_debug(regsel_y, "dbg_y", m_y);
    read_debug(regsel_p, "dbg_p", {m_n, 5'b00000, m_z, 1'b0});
    read_debug(regsel_pcl, "dbg_pcl", pc_end[7:0]);
    read_debug(regsel_pch, "dbg_pch", pc_end[15:8]);
    read_debug(4'hF, "dbg_unused", dbg_default);
    read_debug(4'(6 + ($urandom % 10)), "dbg_unused", dbg_default);
    report_test(t_debug, "debug_reads");

    total  = 0;
    failed = 0;
    for (k = 0; k < 5; k++)
    begin
      total += errs[k];
      if (errs[k] != 0)
        failed++;
    end
    $display("tests 5, passed %0d, failed %0d, errors %0d", 5 - failed, failed, total);
    if (total == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

  // run limit
  initial
  begin
    cycle_count = 0;
    while (cycle_count < clk_limit)
    begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout after %0d clocks, the program never reached its final brk", cycle_count);
    $display("Testbench failed");
    $finish;
  end

endmodule

// File: project.f
cpu_pkg.sv
cpu_ctrl_if.sv
cpu_timing.sv
cpu_decode.sv
cpu_datapath.sv
cpu_top.sv
tb_cpu.sv
